// File: common/id_pkg.sv
package id_pkg;

	localparam int XLEN     = 32;
	localparam int REG_AW   = 5;
	localparam int NUM_REGS = 32;

	typedef logic [XLEN-1:0]   word_t;
	typedef logic [REG_AW-1:0] reg_addr_t;

	localparam reg_addr_t LINK_REG = 5'd31; // jal / bgezal / bltzal destination

	// primary opcodes, inst[31:26]
	localparam logic [5:0] OP_SPECIAL = 6'b000000;
	localparam logic [5:0] OP_REGIMM  = 6'b000001;
	localparam logic [5:0] OP_J       = 6'b000010;
	localparam logic [5:0] OP_JAL     = 6'b000011;
	localparam logic [5:0] OP_BEQ     = 6'b000100;
	localparam logic [5:0] OP_BNE     = 6'b000101;
	localparam logic [5:0] OP_BLEZ    = 6'b000110;
	localparam logic [5:0] OP_BGTZ    = 6'b000111;
	localparam logic [5:0] OP_ADDI    = 6'b001000;
	localparam logic [5:0] OP_ADDIU   = 6'b001001;
	localparam logic [5:0] OP_SLTI    = 6'b001010;
	localparam logic [5:0] OP_SLTIU   = 6'b001011;
	localparam logic [5:0] OP_ANDI    = 6'b001100;
	localparam logic [5:0] OP_ORI     = 6'b001101;
	localparam logic [5:0] OP_XORI    = 6'b001110;
	localparam logic [5:0] OP_LUI     = 6'b001111;

	// SPECIAL function field, inst[5:0]
	localparam logic [5:0] FN_SLL  = 6'b000000;
	localparam logic [5:0] FN_SRL  = 6'b000010;
	localparam logic [5:0] FN_SRA  = 6'b000011;
	localparam logic [5:0] FN_SLLV = 6'b000100;
	localparam logic [5:0] FN_SRLV = 6'b000110;
	localparam logic [5:0] FN_SRAV = 6'b000111;
	localparam logic [5:0] FN_JR   = 6'b001000;
	localparam logic [5:0] FN_JALR = 6'b001001;
	localparam logic [5:0] FN_ADD  = 6'b100000;
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUB  = 6'b100010;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_NOR  = 6'b100111;
	localparam logic [5:0] FN_SLT  = 6'b101010;
	localparam logic [5:0] FN_SLTU = 6'b101011;

	// REGIMM rt field
	localparam logic [4:0] RT_BLTZ   = 5'b00000;
	localparam logic [4:0] RT_BGEZ   = 5'b00001;
	localparam logic [4:0] RT_BLTZAL = 5'b10000;
	localparam logic [4:0] RT_BGEZAL = 5'b10001;

	typedef enum logic [7:0] {
		ALU_NOP    = 8'b0000_0000,
		ALU_OR     = 8'b0010_0101,
		ALU_AND    = 8'b0010_0100,
		ALU_XOR    = 8'b0010_0110,
		ALU_NOR    = 8'b0010_0111,
		ALU_SLL    = 8'b0111_1100,
		ALU_SRL    = 8'b0000_0010,
		ALU_SRA    = 8'b0000_0011,
		ALU_ADD    = 8'b0010_0000,
		ALU_ADDU   = 8'b0010_0001,
		ALU_ADDI   = 8'b0101_0101,
		ALU_ADDIU  = 8'b0101_0110,
		ALU_SUB    = 8'b0010_0010,
		ALU_SUBU   = 8'b0010_0011,
		ALU_SLT    = 8'b0010_1010,
		ALU_SLTU   = 8'b0010_1011,
		ALU_J      = 8'b0100_1111,
		ALU_JAL    = 8'b0101_0000,
		ALU_JR     = 8'b0000_1000,
		ALU_JALR   = 8'b0000_1001,
		ALU_BEQ    = 8'b0101_0001,
		ALU_BNE    = 8'b0101_0010,
		ALU_BGTZ   = 8'b0101_0100,
		ALU_BLEZ   = 8'b0101_0011,
		ALU_BGEZ   = 8'b0100_0001,
		ALU_BLTZ   = 8'b0100_0000,
		ALU_BGEZAL = 8'b0100_1011,
		ALU_BLTZAL = 8'b0100_1010
	} aluop_e;

	typedef enum logic [2:0] {
		SEL_NOP         = 3'b000,
		SEL_LOGIC       = 3'b001,
		SEL_SHIFT       = 3'b010,
		SEL_ARITH       = 3'b100,
		SEL_JUMP_BRANCH = 3'b110
	} alusel_e;

	typedef enum logic [3:0] {
		BR_NONE,
		BR_JUMP, // j / jal, pc region + index
		BR_JREG, // jr / jalr
		BR_EQ,
		BR_NE,
		BR_GTZ,
		BR_LEZ,
		BR_GEZ,
		BR_LTZ
	} br_kind_e;

endpackage

// File: decode/id_decoder.sv
`timescale 1ns/1ps

module id_decoder (
	input  id_pkg::word_t     inst_i,
	output logic              reg1_read_o,
	output logic              reg2_read_o,
	output id_pkg::reg_addr_t reg1_addr_o,
	output id_pkg::reg_addr_t reg2_addr_o,
	output id_pkg::word_t     imm_o,
	output id_pkg::reg_addr_t wd_o,
	output logic              wreg_o,
	output id_pkg::aluop_e    aluop_o,
	output id_pkg::alusel_e   alusel_o,
	output id_pkg::br_kind_e  br_kind_o,
	output logic              link_en_o,
	output logic              illegal_o
);
	import id_pkg::*;

	logic [5:0]  op, funct;
	logic [4:0]  rs, rt, rd, shamt;
	logic [15:0] imm16;
	logic        valid;

	assign op    = inst_i[31:26];
	assign rs    = inst_i[25:21];
	assign rt    = inst_i[20:16];
	assign rd    = inst_i[15:11];
	assign shamt = inst_i[10:6];
	assign funct = inst_i[5:0];
	assign imm16 = inst_i[15:0];

	function automatic aluop_e alu_op_of(input logic [5:0] op_f, input logic [5:0] fn_f,
		input logic [4:0] rt_f);
		case (op_f)
			OP_SPECIAL: begin
				case (fn_f)
					FN_SLL, FN_SLLV: return ALU_SLL;
					FN_SRL, FN_SRLV: return ALU_SRL;
					FN_SRA, FN_SRAV: return ALU_SRA;
					FN_AND:  return ALU_AND;
					FN_OR:   return ALU_OR;
					FN_XOR:  return ALU_XOR;
					FN_NOR:  return ALU_NOR;
					FN_ADD:  return ALU_ADD;
					FN_ADDU: return ALU_ADDU;
					FN_SUB:  return ALU_SUB;
					FN_SUBU: return ALU_SUBU;
					FN_SLT:  return ALU_SLT;
					FN_SLTU: return ALU_SLTU;
					FN_JR:   return ALU_JR;
					FN_JALR: return ALU_JALR;
					default: return ALU_NOP;
				endcase
			end
			OP_REGIMM: begin
				case (rt_f)
					RT_BLTZ:   return ALU_BLTZ;
					RT_BGEZ:   return ALU_BGEZ;
					RT_BLTZAL: return ALU_BLTZAL;
					RT_BGEZAL: return ALU_BGEZAL;
					default:   return ALU_NOP;
				endcase
			end
			OP_ORI, OP_LUI: return ALU_OR; // lui ors the upper imm onto r0
			OP_ANDI:  return ALU_AND;
			OP_XORI:  return ALU_XOR;
			OP_ADDI:  return ALU_ADDI;
			OP_ADDIU: return ALU_ADDIU;
			OP_SLTI:  return ALU_SLT;
			OP_SLTIU: return ALU_SLTU;
			OP_J:     return ALU_J;
			OP_JAL:   return ALU_JAL;
			OP_BEQ:   return ALU_BEQ;
			OP_BNE:   return ALU_BNE;
			OP_BGTZ:  return ALU_BGTZ;
			OP_BLEZ:  return ALU_BLEZ;
			default:  return ALU_NOP;
		endcase
	endfunction

	always_comb begin
		reg1_read_o = 1'b0;
		reg2_read_o = 1'b0;
		reg1_addr_o = rs;
		reg2_addr_o = rt;
		imm_o       = '0;
		wd_o        = rd;
		wreg_o      = 1'b0;
		aluop_o     = alu_op_of(op, funct, rt);
		alusel_o    = SEL_NOP;
		br_kind_o   = BR_NONE;
		link_en_o   = 1'b0;
		valid       = 1'b1;
		case (op)
			OP_SPECIAL: begin
				reg1_read_o = 1'b1;
				reg2_read_o = 1'b1;
				wreg_o      = 1'b1;
				valid       = (shamt == '0);
				case (funct)
					FN_SLL, FN_SRL, FN_SRA: begin
						reg1_read_o = 1'b0; // op1 becomes shamt
						imm_o       = {27'b0, shamt};
						alusel_o    = SEL_SHIFT;
						valid       = (rs == '0);
					end
					FN_SLLV, FN_SRLV, FN_SRAV: alusel_o = SEL_SHIFT;
					FN_AND, FN_OR, FN_XOR, FN_NOR: alusel_o = SEL_LOGIC;
					FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU: alusel_o = SEL_ARITH;
					FN_JR, FN_JALR: begin
						reg2_read_o = 1'b0;
						wreg_o      = (funct == FN_JALR);
						link_en_o   = (funct == FN_JALR);
						alusel_o    = SEL_JUMP_BRANCH;
						br_kind_o   = BR_JREG;
					end
					default: valid = 1'b0;
				endcase
			end
			OP_ORI, OP_ANDI, OP_XORI, OP_LUI: begin
				reg1_read_o = 1'b1;
				wd_o        = rt;
				wreg_o      = 1'b1;
				alusel_o    = SEL_LOGIC;
				imm_o       = (op == OP_LUI) ? {imm16, 16'b0} : {16'b0, imm16};
			end
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
				reg1_read_o = 1'b1;
				wd_o        = rt;
				wreg_o      = 1'b1;
				alusel_o    = SEL_ARITH;
				imm_o       = {{16{imm16[15]}}, imm16};
			end
			OP_J, OP_JAL: begin
				wd_o      = LINK_REG;
				wreg_o    = (op == OP_JAL);
				link_en_o = (op == OP_JAL);
				alusel_o  = SEL_JUMP_BRANCH;
				br_kind_o = BR_JUMP;
			end
			OP_BEQ, OP_BNE: begin
				reg1_read_o = 1'b1;
				reg2_read_o = 1'b1;
				alusel_o    = SEL_JUMP_BRANCH;
				br_kind_o   = (op == OP_BEQ) ? BR_EQ : BR_NE;
			end
			OP_BGTZ, OP_BLEZ: begin
				reg1_read_o = 1'b1;
				alusel_o    = SEL_JUMP_BRANCH;
				br_kind_o   = (op == OP_BGTZ) ? BR_GTZ : BR_LEZ;
				valid       = (rt == '0);
			end
			OP_REGIMM: begin
				reg1_read_o = 1'b1;
				wd_o        = LINK_REG;
				wreg_o      = rt[4]; // the AL forms link
				link_en_o   = rt[4];
				alusel_o    = SEL_JUMP_BRANCH;
				br_kind_o   = rt[0] ? BR_GEZ : BR_LTZ;
				valid       = (rt == RT_BLTZ) || (rt == RT_BGEZ) ||
				              (rt == RT_BLTZAL) || (rt == RT_BGEZAL);
			end
			default: valid = 1'b0;
		endcase
		if (!valid) begin
			reg1_read_o = 1'b0;
			reg2_read_o = 1'b0;
			wreg_o      = 1'b0;
			link_en_o   = 1'b0;
			aluop_o     = ALU_NOP;
			alusel_o    = SEL_NOP;
			br_kind_o   = BR_NONE;
		end
		illegal_o = !valid;
	end

endmodule

// File: decode/operand_fwd.sv
`timescale 1ns/1ps

module operand_fwd (
	input  logic              reg1_read_i,
	input  logic              reg2_read_i,
	input  id_pkg::reg_addr_t reg1_addr_i,
	input  id_pkg::reg_addr_t reg2_addr_i,
	input  id_pkg::word_t     reg1_data_i,
	input  id_pkg::word_t     reg2_data_i,
	input  id_pkg::word_t     imm_i,
	input  logic              ex_wreg_i,
	input  id_pkg::reg_addr_t ex_wd_i,
	input  id_pkg::word_t     ex_wdata_i,
	input  logic              mem_wreg_i,
	input  id_pkg::reg_addr_t mem_wd_i,
	input  id_pkg::word_t     mem_wdata_i,
	output id_pkg::word_t     op1_o,
	output id_pkg::word_t     op2_o
);
	import id_pkg::*;

	// newest producer wins, r0 is never forwarded
	function automatic word_t pick(input logic rd_en, input reg_addr_t addr,
		input word_t rf_data);
		if (!rd_en)
			return imm_i;
		if (ex_wreg_i && (ex_wd_i == addr) && (addr != '0))
			return ex_wdata_i;
		if (mem_wreg_i && (mem_wd_i == addr) && (addr != '0))
			return mem_wdata_i;
		return rf_data;
	endfunction

	always_comb begin
		op1_o = pick(reg1_read_i, reg1_addr_i, reg1_data_i);
		op2_o = pick(reg2_read_i, reg2_addr_i, reg2_data_i);
	end

endmodule

// File: decode/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
	input  id_pkg::word_t    pc_i,
	input  id_pkg::word_t    inst_i,
	input  id_pkg::br_kind_e br_kind_i,
	input  logic             link_en_i,
	input  id_pkg::word_t    op1_i,
	input  id_pkg::word_t    op2_i,
	output logic             taken_o,
	output id_pkg::word_t    target_o,
	output id_pkg::word_t    link_o
);
	import id_pkg::*;

	word_t pc_plus4;
	word_t br_offset;
	logic  op1_neg, op1_zero;

	assign pc_plus4  = pc_i + 32'd4;
	assign br_offset = {{14{inst_i[15]}}, inst_i[15:0], 2'b00};
	assign op1_neg   = op1_i[XLEN-1];
	assign op1_zero  = (op1_i == '0);

	always_comb begin
		case (br_kind_i)
			BR_JUMP, BR_JREG: taken_o = 1'b1;
			BR_EQ:   taken_o = (op1_i == op2_i);
			BR_NE:   taken_o = (op1_i != op2_i);
			BR_GTZ:  taken_o = !op1_neg && !op1_zero;
			BR_LEZ:  taken_o = op1_neg || op1_zero;
			BR_GEZ:  taken_o = !op1_neg;
			BR_LTZ:  taken_o = op1_neg;
			default: taken_o = 1'b0;
		endcase
	end

	always_comb begin
		target_o = '0;
		if (taken_o) begin
			case (br_kind_i)
				BR_JUMP: target_o = {pc_plus4[31:28], inst_i[25:0], 2'b00};
				BR_JREG: target_o = op1_i;
				default: target_o = pc_plus4 + br_offset;
			endcase
		end
	end

	assign link_o = link_en_i ? (pc_i + 32'd8) : '0; // skip the delay slot

endmodule

// File: hw/regfile.sv
`timescale 1ns/1ps

module regfile (
	input  logic              clk,
	input  logic              rst_n_i,
	input  logic              we_i,
	input  id_pkg::reg_addr_t waddr_i,
	input  id_pkg::word_t     wdata_i,
	input  id_pkg::reg_addr_t raddr1_i,
	input  id_pkg::reg_addr_t raddr2_i,
	output id_pkg::word_t     rdata1_o,
	output id_pkg::word_t     rdata2_o
);
	import id_pkg::*;

	word_t regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && (waddr_i != '0)) begin // r0 stays zero
			regs[waddr_i] <= wdata_i;
		end
	end

	// no write bypass, forwarding covers the newest values
	assign rdata1_o = regs[raddr1_i];
	assign rdata2_o = regs[raddr2_i];

endmodule

// File: hw/id_ex_reg.sv
`timescale 1ns/1ps

module id_ex_reg (
	input  logic              clk,
	input  logic              rst_n_i,
	input  logic              in_valid_i,
	output logic              in_ready_o,
	input  logic              ex_ready_i,
	output logic              ex_valid_o,
	input  id_pkg::aluop_e    aluop_i,
	input  id_pkg::alusel_e   alusel_i,
	input  id_pkg::word_t     op1_i,
	input  id_pkg::word_t     op2_i,
	input  id_pkg::reg_addr_t wd_i,
	input  logic              wreg_i,
	input  id_pkg::word_t     link_i,
	input  logic              taken_i,
	input  id_pkg::word_t     target_i,
	input  logic              illegal_i,
	output id_pkg::aluop_e    aluop_o,
	output id_pkg::alusel_e   alusel_o,
	output id_pkg::word_t     op1_o,
	output id_pkg::word_t     op2_o,
	output id_pkg::reg_addr_t wd_o,
	output logic              wreg_o,
	output id_pkg::word_t     link_o,
	output logic              taken_o,
	output id_pkg::word_t     target_o,
	output logic              illegal_o,
	output logic              is_in_delayslot_o
);
	import id_pkg::*;

	logic accept;
	logic delay_slot_q; // last accepted instr was a taken branch

	assign in_ready_o = !ex_valid_o || ex_ready_i;
	assign accept     = in_valid_i && in_ready_o;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			ex_valid_o        <= 1'b0;
			wreg_o            <= 1'b0;
			taken_o           <= 1'b0;
			illegal_o         <= 1'b0;
			is_in_delayslot_o <= 1'b0;
			delay_slot_q      <= 1'b0;
		end else if (accept) begin
			ex_valid_o        <= 1'b1;
			wreg_o            <= wreg_i;
			taken_o           <= taken_i;
			illegal_o         <= illegal_i;
			is_in_delayslot_o <= delay_slot_q;
			delay_slot_q      <= taken_i;
		end else if (ex_ready_i) begin
			ex_valid_o <= 1'b0; // drained
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			aluop_o  <= aluop_i;
			alusel_o <= alusel_i;
			op1_o    <= op1_i;
			op2_o    <= op2_i;
			wd_o     <= wd_i;
			link_o   <= link_i;
			target_o <= target_i;
		end
	end

endmodule

// File: hw/id_top.sv
`timescale 1ns/1ps

module id_top (
	input  logic                clk,
	input  logic                rst_n_i,
	input  logic                inst_valid_i,
	output logic                inst_ready_o,
	input  id_pkg::word_t       pc_i,
	input  id_pkg::word_t       inst_i,
	input  logic                ex_wreg_i,
	input  id_pkg::reg_addr_t   ex_wd_i,
	input  id_pkg::word_t       ex_wdata_i,
	input  logic                mem_wreg_i,
	input  id_pkg::reg_addr_t   mem_wd_i,
	input  id_pkg::word_t       mem_wdata_i,
	input  logic                wb_we_i,
	input  id_pkg::reg_addr_t   wb_addr_i,
	input  id_pkg::word_t       wb_data_i,
	input  logic                ex_ready_i,
	output logic                ex_valid_o,
	output id_pkg::aluop_e      aluop_o,
	output id_pkg::alusel_e     alusel_o,
	output id_pkg::word_t       reg1_o,
	output id_pkg::word_t       reg2_o,
	output id_pkg::reg_addr_t   wd_o,
	output logic                wreg_o,
	output id_pkg::word_t       link_addr_o,
	output logic                branch_flag_o,
	output id_pkg::word_t       branch_target_o,
	output logic                is_in_delayslot_o,
	output logic                illegal_o
);
	import id_pkg::*;

	logic      reg1_read, reg2_read;
	reg_addr_t reg1_addr, reg2_addr;
	word_t     reg1_data, reg2_data;
	word_t     imm, op1, op2;
	reg_addr_t dec_wd;
	logic      dec_wreg, link_en, dec_illegal;
	aluop_e    dec_aluop;
	alusel_e   dec_alusel;
	br_kind_e  br_kind;
	logic      taken;
	word_t     target, link;

	id_decoder u_decoder (
		.inst_i      (inst_i),
		.reg1_read_o (reg1_read),
		.reg2_read_o (reg2_read),
		.reg1_addr_o (reg1_addr),
		.reg2_addr_o (reg2_addr),
		.imm_o       (imm),
		.wd_o        (dec_wd),
		.wreg_o      (dec_wreg),
		.aluop_o     (dec_aluop),
		.alusel_o    (dec_alusel),
		.br_kind_o   (br_kind),
		.link_en_o   (link_en),
		.illegal_o   (dec_illegal)
	);

	regfile u_regfile (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.we_i     (wb_we_i),
		.waddr_i  (wb_addr_i),
		.wdata_i  (wb_data_i),
		.raddr1_i (reg1_addr),
		.raddr2_i (reg2_addr),
		.rdata1_o (reg1_data),
		.rdata2_o (reg2_data)
	);

	operand_fwd u_fwd (
		.reg1_read_i (reg1_read),
		.reg2_read_i (reg2_read),
		.reg1_addr_i (reg1_addr),
		.reg2_addr_i (reg2_addr),
		.reg1_data_i (reg1_data),
		.reg2_data_i (reg2_data),
		.imm_i       (imm),
		.ex_wreg_i   (ex_wreg_i),
		.ex_wd_i     (ex_wd_i),
		.ex_wdata_i  (ex_wdata_i),
		.mem_wreg_i  (mem_wreg_i),
		.mem_wd_i    (mem_wd_i),
		.mem_wdata_i (mem_wdata_i),
		.op1_o       (op1),
		.op2_o       (op2)
	);

	branch_unit u_branch (
		.pc_i      (pc_i),
		.inst_i    (inst_i),
		.br_kind_i (br_kind),
		.link_en_i (link_en),
		.op1_i     (op1),
		.op2_i     (op2),
		.taken_o   (taken),
		.target_o  (target),
		.link_o    (link)
	);

	id_ex_reg u_id_ex (
		.clk               (clk),
		.rst_n_i           (rst_n_i),
		.in_valid_i        (inst_valid_i),
		.in_ready_o        (inst_ready_o),
		.ex_ready_i        (ex_ready_i),
		.ex_valid_o        (ex_valid_o),
		.aluop_i           (dec_aluop),
		.alusel_i          (dec_alusel),
		.op1_i             (op1),
		.op2_i             (op2),
		.wd_i              (dec_wd),
		.wreg_i            (dec_wreg),
		.link_i            (link),
		.taken_i           (taken),
		.target_i          (target),
		.illegal_i         (dec_illegal),
		.aluop_o           (aluop_o),
		.alusel_o          (alusel_o),
		.op1_o             (reg1_o),
		.op2_o             (reg2_o),
		.wd_o              (wd_o),
		.wreg_o            (wreg_o),
		.link_o            (link_addr_o),
		.taken_o           (branch_flag_o),
		.target_o          (branch_target_o),
		.illegal_o         (illegal_o),
		.is_in_delayslot_o (is_in_delayslot_o)
	);

endmodule

// File: verification/tb_id_checks.svh
`ifndef TB_ID_CHECKS_SVH
`define TB_ID_CHECKS_SVH

task automatic check_word(input string name, input word_t exp, input word_t act);
	if (act !== exp) begin
		$display("ERROR %0t: %s expected %h, got %h", $time, name, exp, act);
		errors++;
	end
endtask

task automatic check_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
	if (act !== exp) begin
		$display("ERROR %0t: %s expected r%0d, got r%0d", $time, name, exp, act);
		errors++;
	end
endtask

task automatic check_aluop(input string name, input aluop_e exp, input aluop_e act);
	if (act !== exp) begin
		$display("ERROR %0t: %s expected %s(%h), got %s(%h)", $time, name,
			exp.name(), exp, act.name(), act);
		errors++;
	end
endtask

task automatic check_alusel(input string name, input alusel_e exp, input alusel_e act);
	if (act !== exp) begin
		$display("ERROR %0t: %s expected %s(%b), got %s(%b)", $time, name,
			exp.name(), exp, act.name(), act);
		errors++;
	end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
	if (act !== exp) begin
		$display("ERROR %0t: %s expected %b, got %b", $time, name, exp, act);
		errors++;
	end
endtask

// instruction word builders
function automatic word_t r_type(input reg_addr_t rs, input reg_addr_t rt,
	input reg_addr_t rd, input logic [4:0] sa, input logic [5:0] fn);
	return {OP_SPECIAL, rs, rt, rd, sa, fn};
endfunction

function automatic word_t i_type(input logic [5:0] op, input reg_addr_t rs,
	input reg_addr_t rt, input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

function automatic word_t j_type(input logic [5:0] op, input logic [25:0] idx);
	return {op, idx};
endfunction

`endif

// File: verification/tb_id_top.sv
`timescale 1ns/1ps

module tb_id_top;
	import id_pkg::*;

	localparam logic [31:0] SEED = 32'h0f08_9890;
	// rough cycle budget per test
	localparam int LEN_RESET  = 12;
	localparam int LEN_ALU    = 80;
	localparam int LEN_FWD    = 40;
	localparam int LEN_BRANCH = 70;
	localparam int LEN_DSLOT  = 30;
	localparam int LEN_BP     = 50;
	localparam int LEN_ILL    = 18;
	localparam int MAX_CYCLES = 2 * (LEN_RESET + LEN_ALU + LEN_FWD + LEN_BRANCH +
	                                 LEN_DSLOT + LEN_BP + LEN_ILL);

	logic      clk = 1'b0;
	logic      rst_n_i;
	logic      inst_valid_i, inst_ready_o;
	word_t     pc_i, inst_i;
	logic      ex_wreg_i, mem_wreg_i, wb_we_i;
	reg_addr_t ex_wd_i, mem_wd_i, wb_addr_i;
	word_t     ex_wdata_i, mem_wdata_i, wb_data_i;
	logic      ex_ready_i, ex_valid_o;
	aluop_e    aluop_o;
	alusel_e   alusel_o;
	word_t     reg1_o, reg2_o, link_addr_o, branch_target_o;
	reg_addr_t wd_o;
	logic      wreg_o, branch_flag_o, is_in_delayslot_o, illegal_o;

	int    errors = 0;
	int    cycles = 0;
	word_t rf_model [NUM_REGS];
	word_t fetch_pc;

	`include "tb_id_checks.svh"

	id_top uut (
		.clk               (clk),
		.rst_n_i           (rst_n_i),
		.inst_valid_i      (inst_valid_i),
		.inst_ready_o      (inst_ready_o),
		.pc_i              (pc_i),
		.inst_i            (inst_i),
		.ex_wreg_i         (ex_wreg_i),
		.ex_wd_i           (ex_wd_i),
		.ex_wdata_i        (ex_wdata_i),
		.mem_wreg_i        (mem_wreg_i),
		.mem_wd_i          (mem_wd_i),
		.mem_wdata_i       (mem_wdata_i),
		.wb_we_i           (wb_we_i),
		.wb_addr_i         (wb_addr_i),
		.wb_data_i         (wb_data_i),
		.ex_ready_i        (ex_ready_i),
		.ex_valid_o        (ex_valid_o),
		.aluop_o           (aluop_o),
		.alusel_o          (alusel_o),
		.reg1_o            (reg1_o),
		.reg2_o            (reg2_o),
		.wd_o              (wd_o),
		.wreg_o            (wreg_o),
		.link_addr_o       (link_addr_o),
		.branch_flag_o     (branch_flag_o),
		.branch_target_o   (branch_target_o),
		.is_in_delayslot_o (is_in_delayslot_o),
		.illegal_o         (illegal_o)
	);

	always #4 clk = ~clk; // 8 ns period

	always @(posedge clk) begin
		cycles++;
		if (cycles > MAX_CYCLES) begin
			$display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic word_t rand_word();
		return $urandom();
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic write_reg(input reg_addr_t addr, input word_t data);
		wb_we_i   = 1'b1;
		wb_addr_i = addr;
		wb_data_i = data;
		next_cycle();
		wb_we_i = 1'b0;
		if (addr != 5'd0)
			rf_model[addr] = data;
	endtask

	// offer one instruction and wait for the handshake
	task automatic issue(input word_t inst);
		logic rdy;
		pc_i         = fetch_pc;
		inst_i       = inst;
		inst_valid_i = 1'b1;
		do begin
			#2;
			rdy = inst_ready_o;
			next_cycle();
		end while (!rdy);
		inst_valid_i = 1'b0;
		fetch_pc     = fetch_pc + 32'd4;
		check_bit("ex_valid_o", 1'b1, ex_valid_o);
	endtask

	task automatic check_decode(input aluop_e op, input alusel_e sel, input word_t r1,
		input word_t r2, input reg_addr_t wd);
		check_aluop("aluop_o", op, aluop_o);
		check_alusel("alusel_o", sel, alusel_o);
		check_word("reg1_o", r1, reg1_o);
		check_word("reg2_o", r2, reg2_o);
		check_addr("wd_o", wd, wd_o);
		check_bit("wreg_o", 1'b1, wreg_o);
	endtask

	task automatic cond_branch(input word_t inst, input logic exp_taken);
		word_t exp_target;
		exp_target = '0;
		if (exp_taken)
			exp_target = fetch_pc + 32'd4 + {{14{inst[15]}}, inst[15:0], 2'b00};
		issue(inst);
		check_bit("branch_flag_o", exp_taken, branch_flag_o);
		check_word("branch_target_o", exp_target, branch_target_o);
		check_bit("wreg_o", 1'b0, wreg_o);
	endtask

	task automatic alu_decode_test();
		word_t       r;
		logic [15:0] imm;
		logic [4:0]  sa;
		for (int i = 1; i <= 8; i++) begin
			write_reg(reg_addr_t'(i), rand_word());
		end
		issue(r_type(5'd1, 5'd2, 5'd10, 5'd0, FN_ADDU));
		check_decode(ALU_ADDU, SEL_ARITH, rf_model[1], rf_model[2], 5'd10);
		issue(r_type(5'd3, 5'd4, 5'd11, 5'd0, FN_OR));
		check_decode(ALU_OR, SEL_LOGIC, rf_model[3], rf_model[4], 5'd11);
		r   = rand_word();
		imm = r[15:0];
		sa  = r[20:16];
		issue(i_type(OP_ORI, 5'd5, 5'd12, imm)); // zero extended
		check_decode(ALU_OR, SEL_LOGIC, rf_model[5], {16'h0, imm}, 5'd12);
		issue(i_type(OP_LUI, 5'd0, 5'd13, imm));
		check_decode(ALU_OR, SEL_LOGIC, 32'h0, {imm, 16'h0}, 5'd13);
		issue(r_type(5'd0, 5'd6, 5'd14, sa, FN_SLL));
		check_decode(ALU_SLL, SEL_SHIFT, {27'h0, sa}, rf_model[6], 5'd14);
		imm = r[31:16] | 16'h8000;
		issue(i_type(OP_ADDIU, 5'd7, 5'd15, imm)); // sign extended
		check_decode(ALU_ADDIU, SEL_ARITH, rf_model[7], {{16{imm[15]}}, imm}, 5'd15);
	endtask

	task automatic forward_test();
		word_t ex_val, mem_val, junk;
		ex_val      = rand_word();
		mem_val     = rand_word();
		ex_wreg_i   = 1'b1;
		ex_wd_i     = 5'd7;
		ex_wdata_i  = ex_val;
		mem_wreg_i  = 1'b1;
		mem_wd_i    = 5'd7;
		mem_wdata_i = mem_val;
		issue(r_type(5'd7, 5'd0, 5'd20, 5'd0, FN_OR));
		check_word("reg1_o", ex_val, reg1_o);
		ex_wd_i = 5'd9; // only mem still matches
		issue(r_type(5'd7, 5'd0, 5'd20, 5'd0, FN_OR));
		check_word("reg1_o", mem_val, reg1_o);
		mem_wreg_i = 1'b0;
		issue(r_type(5'd7, 5'd0, 5'd20, 5'd0, FN_OR));
		check_word("reg1_o", rf_model[7], reg1_o);
		junk = rand_word() | 32'h1;
		write_reg(5'd0, junk);
		ex_wd_i    = 5'd0;
		ex_wdata_i = junk;
		issue(r_type(5'd0, 5'd0, 5'd21, 5'd0, FN_OR));
		check_word("reg1_o", 32'h0, reg1_o);
		check_word("reg2_o", 32'h0, reg2_o);
		ex_wreg_i = 1'b0;
	endtask

	task automatic branch_test();
		word_t       r, pc, pc4;
		logic [15:0] off;
		logic [25:0] idx;
		r = rand_word();
		write_reg(5'd16, {1'b0, r[30:1], 1'b1}); // positive
		write_reg(5'd17, r | 32'h8000_0000);     // negative
		write_reg(5'd18, 32'h0);
		write_reg(5'd19, rf_model[16]);
		off = r[15:0];
		cond_branch(i_type(OP_BEQ, 5'd16, 5'd19, off), 1'b1);
		cond_branch(i_type(OP_BEQ, 5'd16, 5'd17, off), 1'b0);
		cond_branch(i_type(OP_BNE, 5'd16, 5'd17, ~off), 1'b1);
		cond_branch(i_type(OP_BNE, 5'd16, 5'd19, off), 1'b0);
		cond_branch(i_type(OP_BGTZ, 5'd16, 5'd0, off), 1'b1);
		cond_branch(i_type(OP_BGTZ, 5'd18, 5'd0, off), 1'b0);
		cond_branch(i_type(OP_BGTZ, 5'd17, 5'd0, off), 1'b0);
		cond_branch(i_type(OP_BLEZ, 5'd17, 5'd0, ~off), 1'b1);
		cond_branch(i_type(OP_BLEZ, 5'd18, 5'd0, off), 1'b1);
		cond_branch(i_type(OP_BLEZ, 5'd16, 5'd0, off), 1'b0);
		cond_branch(i_type(OP_REGIMM, 5'd18, RT_BGEZ, off), 1'b1);
		cond_branch(i_type(OP_REGIMM, 5'd17, RT_BGEZ, off), 1'b0);
		cond_branch(i_type(OP_REGIMM, 5'd17, RT_BLTZ, ~off), 1'b1);
		cond_branch(i_type(OP_REGIMM, 5'd18, RT_BLTZ, off), 1'b0);
		r   = rand_word();
		idx = r[25:0];
		pc  = fetch_pc;
		pc4 = pc + 32'd4;
		issue(j_type(OP_JAL, idx));
		check_aluop("aluop_o", ALU_JAL, aluop_o);
		check_addr("wd_o", LINK_REG, wd_o);
		check_bit("wreg_o", 1'b1, wreg_o);
		check_word("link_addr_o", pc + 32'd8, link_addr_o);
		check_bit("branch_flag_o", 1'b1, branch_flag_o);
		check_word("branch_target_o", {pc4[31:28], idx, 2'b00}, branch_target_o);
	endtask

	task automatic delay_slot_test();
		issue(i_type(OP_ORI, 5'd0, 5'd22, 16'h0001));
		cond_branch(i_type(OP_BEQ, 5'd16, 5'd19, 16'h0010), 1'b1);
		check_bit("is_in_delayslot_o", 1'b0, is_in_delayslot_o);
		issue(i_type(OP_ORI, 5'd0, 5'd22, 16'h0002)); // sits in the slot
		check_bit("is_in_delayslot_o", 1'b1, is_in_delayslot_o);
		cond_branch(i_type(OP_BNE, 5'd16, 5'd19, 16'h0010), 1'b0);
		check_bit("is_in_delayslot_o", 1'b0, is_in_delayslot_o);
		issue(i_type(OP_ORI, 5'd0, 5'd22, 16'h0003));
		check_bit("is_in_delayslot_o", 1'b0, is_in_delayslot_o);
	endtask

	task automatic backpressure_test();
		issue(r_type(5'd1, 5'd2, 5'd23, 5'd0, FN_ADDU));
		ex_ready_i   = 1'b0;
		pc_i         = fetch_pc;
		inst_i       = r_type(5'd3, 5'd4, 5'd24, 5'd0, FN_OR);
		inst_valid_i = 1'b1;
		for (int i = 0; i < 4; i++) begin
			#2;
			check_bit("inst_ready_o", 1'b0, inst_ready_o);
			next_cycle();
			check_bit("ex_valid_o", 1'b1, ex_valid_o);
			check_aluop("aluop_o", ALU_ADDU, aluop_o);
			check_addr("wd_o", 5'd23, wd_o);
			check_word("reg1_o", rf_model[1], reg1_o);
		end
		ex_ready_i = 1'b1;
		issue(r_type(5'd3, 5'd4, 5'd24, 5'd0, FN_OR));
		check_decode(ALU_OR, SEL_LOGIC, rf_model[3], rf_model[4], 5'd24);
		issue(i_type(OP_ORI, 5'd5, 5'd25, 16'h00ff));
		check_addr("wd_o", 5'd25, wd_o);
		issue(r_type(5'd0, 5'd6, 5'd26, 5'd3, FN_SLL));
		check_addr("wd_o", 5'd26, wd_o);
		next_cycle();
		check_bit("ex_valid_o", 1'b0, ex_valid_o); // nothing repeated
	endtask

	task automatic illegal_test();
		word_t r;
		r = rand_word();
		issue({6'b111111, r[25:0]});
		check_bit("illegal_o", 1'b1, illegal_o);
		check_bit("wreg_o", 1'b0, wreg_o);
		check_bit("branch_flag_o", 1'b0, branch_flag_o);
		check_aluop("aluop_o", ALU_NOP, aluop_o);
		issue(r_type(5'd1, 5'd2, 5'd27, 5'd0, 6'b111111));
		check_bit("illegal_o", 1'b1, illegal_o);
		check_bit("wreg_o", 1'b0, wreg_o);
		issue(r_type(5'd1, 5'd2, 5'd27, 5'd0, FN_SUBU));
		check_bit("illegal_o", 1'b0, illegal_o);
	endtask

	initial begin
		void'($urandom(SEED));
		rst_n_i      = 1'b0;
		inst_valid_i = 1'b0;
		pc_i         = '0;
		inst_i       = '0;
		ex_wreg_i    = 1'b0;
		ex_wd_i      = '0;
		ex_wdata_i   = '0;
		mem_wreg_i   = 1'b0;
		mem_wd_i     = '0;
		mem_wdata_i  = '0;
		wb_we_i      = 1'b0;
		wb_addr_i    = '0;
		wb_data_i    = '0;
		ex_ready_i   = 1'b1;
		fetch_pc     = 32'hbfc0_0000;
		foreach (rf_model[i])
			rf_model[i] = '0;
		repeat (10) @(posedge clk);
		#1;
		rst_n_i = 1'b1;
		check_bit("ex_valid_o", 1'b0, ex_valid_o);
		check_bit("wreg_o", 1'b0, wreg_o);
		check_bit("branch_flag_o", 1'b0, branch_flag_o);
		check_bit("is_in_delayslot_o", 1'b0, is_in_delayslot_o);
		alu_decode_test();
		forward_test();
		branch_test();
		delay_slot_test();
		backpressure_test();
		illegal_test();
		$display("checks finished after %0d cycles with %0d errors", cycles, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: filelist.f
+incdir+verification
common/id_pkg.sv
decode/id_decoder.sv
decode/operand_fwd.sv
decode/branch_unit.sv
hw/regfile.sv
hw/id_ex_reg.sv
hw/id_top.sv
verification/tb_id_top.sv

// File: run_sim.sh
#!/bin/sh
# build the ID stage testbench with Verilator, run it, and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps --top-module tb_id_top \
	-f filelist.f -o sim_id_top > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_id_top > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
exit 0
